/* Bender.yml */
package:
  name: alu_exec

sources:
  - rtl/alu_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/alu_shift.sv
  - rtl/alu_add.sv
  - rtl/alu_logic.sv
  - rtl/alu_core.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - verif/alu_tb.sv

/* rtl/alu_add.sv */
/*
 * 64-bit adder/subtractor with signed and unsigned less-than
 */
`timescale 1ns/10ps

module alu_add (
    input  alu_pkg::bus64_t a_i,
    input  alu_pkg::bus64_t b_i,
    input  logic            sub_i,
    output alu_pkg::bus64_t sum_o,
    output logic            lt_o,
    output logic            ltu_o
);

    alu_pkg::bus64_t b_eff;
    logic [64:0]     sum_full;
    logic            carry;

    // two's complement subtract, invert b and carry in one
    assign b_eff    = sub_i ? ~b_i : b_i;
    assign sum_full = {1'b0, a_i} + {1'b0, b_eff} + {64'b0, sub_i};

    assign sum_o = sum_full[63:0];
    assign carry = sum_full[64];

    // no carry out of a - b means a < b unsigned
    assign ltu_o = ~carry;

    // on differing signs the negative operand is smaller,
    // otherwise the difference cannot overflow and its sign decides
    always_comb begin
        if (a_i[63] != b_i[63]) begin
            lt_o = a_i[63];
        end else begin
            lt_o = sum_full[63];
        end
    end

endmodule

/* rtl/alu_core.sv */
/*
 * combinational ALU core: operand prep, unit select,
 * bit-op and word post-processing
 */
`timescale 1ns/10ps

module alu_core #(
    parameter int unsigned TagWidth = alu_pkg::TAG_W
) (
    input  alu_pkg::alu_req_t  req_i,
    output alu_pkg::alu_resp_t resp_o
);

    alu_pkg::bus64_t     rs1_shift;
    alu_pkg::bus64_t     shift_res;
    alu_pkg::bus64_t     sum_res;
    alu_pkg::bus64_t     logic_res;
    alu_pkg::bus64_t     unit_res;
    alu_pkg::bus64_t     final_res;
    logic                sub;
    logic                lt;
    logic                ltu;
    logic                is_word;
    logic [TagWidth-1:0] tag;

    // SLLIUW shifts the zero-extended low word
    assign rs1_shift = (req_i.op == alu_pkg::SLLIUW) ? {32'b0, req_i.rs1[31:0]} : req_i.rs1;

    // compares reuse the subtractor
    assign sub = (req_i.op == alu_pkg::SUB) || (req_i.op == alu_pkg::SUBW) ||
                 (req_i.op == alu_pkg::SLT) || (req_i.op == alu_pkg::SLTU);

    alu_shift u_shift (
        .data_rs1_i (rs1_shift),
        .data_rs2_i (req_i.rs2),
        .op_i       (req_i.op),
        .result_o   (shift_res)
    );

    alu_add u_add (
        .a_i   (req_i.rs1),
        .b_i   (req_i.rs2),
        .sub_i (sub),
        .sum_o (sum_res),
        .lt_o  (lt),
        .ltu_o (ltu)
    );

    alu_logic u_logic (
        .a_i      (req_i.rs1),
        .b_i      (req_i.rs2),
        .op_i     (req_i.op),
        .result_o (logic_res)
    );

    always_comb begin
        case (req_i.op)
            alu_pkg::ADD, alu_pkg::SUB,
            alu_pkg::ADDW, alu_pkg::SUBW: unit_res = sum_res;
            alu_pkg::SLT:                 unit_res = {63'b0, lt};
            alu_pkg::SLTU:                unit_res = {63'b0, ltu};
            alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR,
            alu_pkg::ANDN, alu_pkg::ORN,
            alu_pkg::XNOR:                unit_res = logic_res;
            // shifter output is a one-hot mask here
            alu_pkg::BSET:                unit_res = req_i.rs1 | shift_res;
            alu_pkg::BCLR:                unit_res = req_i.rs1 & ~shift_res;
            alu_pkg::BINV:                unit_res = req_i.rs1 ^ shift_res;
            alu_pkg::BEXT:                unit_res = {63'b0, shift_res[0]};
            default:                      unit_res = shift_res;
        endcase
    end

    // 32-bit ops return a sign-extended low word
    assign is_word = (req_i.op == alu_pkg::ADDW) || (req_i.op == alu_pkg::SUBW) ||
                     (req_i.op == alu_pkg::SLLW) || (req_i.op == alu_pkg::SRLW) ||
                     (req_i.op == alu_pkg::SRAW) || (req_i.op == alu_pkg::ROLW) ||
                     (req_i.op == alu_pkg::RORW);

    assign final_res = is_word ? {{32{unit_res[31]}}, unit_res[31:0]} : unit_res;

    assign tag = req_i.tag;

    always_comb begin
        resp_o.result = final_res;
        resp_o.tag    = tag;
    end

endmodule

/* rtl/alu_logic.sv */
/*
 * bitwise operations, plain and with inverted second operand
 */
`timescale 1ns/10ps

module alu_logic (
    input  alu_pkg::bus64_t  a_i,
    input  alu_pkg::bus64_t  b_i,
    input  alu_pkg::alu_op_t op_i,
    output alu_pkg::bus64_t  result_o
);

    logic            invert_b;
    alu_pkg::bus64_t b_eff;

    // Zbb forms share the gates of the base ops
    assign invert_b = (op_i == alu_pkg::ANDN) || (op_i == alu_pkg::ORN) ||
                      (op_i == alu_pkg::XNOR);
    assign b_eff    = invert_b ? ~b_i : b_i;

    always_comb begin
        case (op_i)
            alu_pkg::AND, alu_pkg::ANDN: result_o = a_i & b_eff;
            alu_pkg::OR, alu_pkg::ORN:   result_o = a_i | b_eff;
            alu_pkg::XOR, alu_pkg::XNOR: result_o = a_i ^ b_eff;
            default:                     result_o = '0;
        endcase
    end

endmodule

/* rtl/alu_pkg.sv */
/*
 * shared ALU types: operand word, operation encoding,
 * request and response payloads
 */
package alu_pkg;

    // default tag width, sizes the payload structs
    localparam int unsigned TAG_W = 4;

    typedef logic [63:0] bus64_t;

    // explicit codes, the vector file refers to them by number
    typedef enum logic [4:0] {
        // arithmetic and compare
        ADD    = 5'd0,
        SUB    = 5'd1,
        ADDW   = 5'd2,
        SUBW   = 5'd3,
        SLT    = 5'd4,
        SLTU   = 5'd5,
        // bitwise
        AND    = 5'd6,
        OR     = 5'd7,
        XOR    = 5'd8,
        ANDN   = 5'd9,
        ORN    = 5'd10,
        XNOR   = 5'd11,
        // shifts
        SLL    = 5'd12,
        SRL    = 5'd13,
        SRA    = 5'd14,
        SLLW   = 5'd15,
        SRLW   = 5'd16,
        SRAW   = 5'd17,
        SLLIUW = 5'd18,
        // rotates
        ROL    = 5'd19,
        ROR    = 5'd20,
        ROLW   = 5'd21,
        RORW   = 5'd22,
        // single-bit
        BSET   = 5'd23,
        BCLR   = 5'd24,
        BINV   = 5'd25,
        BEXT   = 5'd26
    } alu_op_t;

    // request into the execute block
    typedef struct packed {
        alu_op_t           op;
        bus64_t            rs1;
        bus64_t            rs2;
        logic [TAG_W-1:0]  tag;
    } alu_req_t;

    // result with the tag of its request
    typedef struct packed {
        bus64_t            result;
        logic [TAG_W-1:0]  tag;
    } alu_resp_t;

endpackage

/* rtl/alu_shift.sv */
/*
 * 127-bit funnel shifter for shifts, rotates and single-bit masks
 */
`timescale 1ns/10ps

module alu_shift (
    input  alu_pkg::bus64_t  data_rs1_i,
    input  alu_pkg::bus64_t  data_rs2_i,
    input  alu_pkg::alu_op_t op_i,
    output alu_pkg::bus64_t  result_o
);

    logic [126:0] base_shifting;
    logic [6:0]   amount_shifting;
    logic [126:0] shifted;

    // base word, the wanted bits end up in the low 64 after a right shift
    always_comb begin
        case (op_i)
            alu_pkg::SRL: begin
                base_shifting = {63'b0, data_rs1_i};
            end
            alu_pkg::SRA, alu_pkg::BEXT: begin
                base_shifting = {{63{data_rs1_i[63]}}, data_rs1_i};
            end
            alu_pkg::SRLW: begin
                base_shifting = {95'b0, data_rs1_i[31:0]};
            end
            alu_pkg::SRAW: begin
                base_shifting = {{95{data_rs1_i[31]}}, data_rs1_i[31:0]};
            end
            alu_pkg::ROR: begin
                base_shifting = {data_rs1_i[62:0], data_rs1_i};
            end
            // low word doubled, a 64-bit shift then rotates 32 bits
            alu_pkg::RORW: begin
                base_shifting = {63'b0, data_rs1_i[31:0], data_rs1_i[31:0]};
            end
            alu_pkg::SLL, alu_pkg::SLLW, alu_pkg::SLLIUW: begin
                base_shifting = {data_rs1_i, 63'b0};
            end
            alu_pkg::ROL: begin
                base_shifting = {data_rs1_i, data_rs1_i[63:1]};
            end
            alu_pkg::ROLW: begin
                base_shifting = {32'b0, data_rs1_i[31:0], data_rs1_i[31:0], 31'b0};
            end
            // single one at bit 63, becomes 1 << n
            alu_pkg::BSET, alu_pkg::BCLR, alu_pkg::BINV: begin
                base_shifting = {63'b0, 1'b1, 63'b0};
            end
            default: begin
                base_shifting = '0;
            end
        endcase
    end

    // left moves turn into right shifts by 63 - n
    always_comb begin
        case (op_i)
            alu_pkg::SLL, alu_pkg::SLLIUW, alu_pkg::ROL,
            alu_pkg::BSET, alu_pkg::BCLR, alu_pkg::BINV: begin
                amount_shifting = {1'b0, ~data_rs2_i[5:0]};
            end
            alu_pkg::SRLW, alu_pkg::SRAW, alu_pkg::RORW: begin
                amount_shifting = {2'b00, data_rs2_i[4:0]};
            end
            alu_pkg::SLLW, alu_pkg::ROLW: begin
                amount_shifting = {2'b01, ~data_rs2_i[4:0]};
            end
            default: begin
                amount_shifting = {1'b0, data_rs2_i[5:0]};
            end
        endcase
    end

    assign shifted  = base_shifting >> amount_shifting;
    assign result_o = shifted[63:0];

endmodule

/* rtl/alu_top.sv */
/*
 * ALU execute block: input register, core, output register
 */
`timescale 1ns/10ps

module alu_top #(
    parameter int unsigned TagWidth = alu_pkg::TAG_W
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // request side
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  alu_pkg::alu_req_t  req_i,
    // response side
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output alu_pkg::alu_resp_t resp_o
);

    logic               stage_valid;
    logic               stage_ready;
    alu_pkg::alu_req_t  stage_req;
    alu_pkg::alu_resp_t core_resp;

    pipe_reg #(
        .payload_t (alu_pkg::alu_req_t)
    ) u_req_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (req_valid_i),
        .ready_o  (req_ready_o),
        .data_i   (req_i),
        .valid_o  (stage_valid),
        .ready_i  (stage_ready),
        .data_o   (stage_req)
    );

    alu_core #(
        .TagWidth (TagWidth)
    ) u_core (
        .req_i  (stage_req),
        .resp_o (core_resp)
    );

    // handshake skips the core, it has no state
    pipe_reg #(
        .payload_t (alu_pkg::alu_resp_t)
    ) u_resp_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (stage_valid),
        .ready_o  (stage_ready),
        .data_i   (core_resp),
        .valid_o  (resp_valid_o),
        .ready_i  (resp_ready_i),
        .data_o   (resp_o)
    );

endmodule

/* rtl/pipe_reg.sv */
/*
 * one-entry valid/ready pipeline register, any payload type
 */
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    // downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // free slot, or the held item leaves this cycle
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

/* tb.f */
rtl/alu_pkg.sv
rtl/pipe_reg.sv
rtl/alu_shift.sv
rtl/alu_add.sv
rtl/alu_logic.sv
rtl/alu_core.sv
rtl/alu_top.sv
verif/alu_tb.sv

/* verif/alu_tb.sv */
/*
 * testbench for the ALU execute block: vector reader, request driver,
 * random-stall sink, response checks and watchdog
 */
`timescale 1ns/10ps

module alu_tb;

    logic               clk_i;
    logic               arst_n_i;
    logic               req_valid_i;
    logic               req_ready_o;
    alu_pkg::alu_req_t  req_i;
    logic               resp_valid_o;
    logic               resp_ready_i;
    alu_pkg::alu_resp_t resp_o;

    // vectors from the data file
    alu_pkg::alu_op_t vec_op[$];
    alu_pkg::bus64_t  vec_rs1[$];
    alu_pkg::bus64_t  vec_rs2[$];
    alu_pkg::bus64_t  vec_exp[$];

    // cycle of each accepted request, in order
    int unsigned accept_cycle[$];

    int unsigned num_vec         = 0;
    int unsigned total_reqs      = 0;
    int unsigned resp_count      = 0;
    int unsigned cycle_cnt       = 0;
    int unsigned last_resp_cycle = 0;
    logic        burst_mode      = 1'b1;
    logic        vectors_loaded  = 1'b0;

    alu_top #(
        .TagWidth (alu_pkg::TAG_W)
    ) dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input alu_pkg::bus64_t exp_val,
                                input alu_pkg::bus64_t act_val);
        if (exp_val !== act_val) begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_tag(input logic [alu_pkg::TAG_W-1:0] exp_tag,
                             input logic [alu_pkg::TAG_W-1:0] act_tag);
        if (exp_tag !== act_tag) begin
            $display("Mismatch at %0t: resp_o.tag expected %h, actual %h", $time, exp_tag, act_tag);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int unsigned exp_cyc,
                                input int unsigned act_cyc);
        if (exp_cyc != act_cyc) begin
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp_cyc, act_cyc);
            abort_run();
        end
    endtask

    // tag of request number idx
    function automatic logic [alu_pkg::TAG_W-1:0] tag_for(input int unsigned idx);
        int unsigned t;
        t = idx % 16;
        return t[alu_pkg::TAG_W-1:0];
    endfunction

    task automatic load_vectors();
        int              fd;
        int              count;
        string           line;
        logic [7:0]      op_code;
        alu_pkg::bus64_t rs1;
        alu_pkg::bus64_t rs2;
        alu_pkg::bus64_t exp_val;
        fd = $fopen("verif/alu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file verif/alu_vectors.txt");
            abort_run();
        end else begin
            // comment and blank lines scan no field
            while ($fgets(line, fd) != 0) begin
                count = $sscanf(line, "%h %h %h %h", op_code, rs1, rs2, exp_val);
                if (count == 4 && op_code <= 8'd26) begin
                    vec_op.push_back(alu_pkg::alu_op_t'(op_code[4:0]));
                    vec_rs1.push_back(rs1);
                    vec_rs2.push_back(rs2);
                    vec_exp.push_back(exp_val);
                end else if (count > 0) begin
                    $display("malformed line in the vector file: %s", line);
                    abort_run();
                end
            end
            $fclose(fd);
            num_vec = vec_op.size();
        end
    endtask

    // holds valid and payload until the handshake
    task automatic send_request(input int unsigned idx);
        int unsigned vec;
        logic        taken;
        vec         = idx % num_vec;
        req_valid_i = 1'b1;
        req_i.op    = vec_op[vec];
        req_i.rs1   = vec_rs1[vec];
        req_i.rs2   = vec_rs2[vec];
        req_i.tag   = tag_for(idx);
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = req_ready_o;
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic check_response();
        int unsigned vec;
        if (resp_count >= total_reqs) begin
            $display("a response with tag %h arrived after the last request", resp_o.tag);
            abort_run();
        end else begin
            vec = resp_count % num_vec;
            check_tag(tag_for(resp_count), resp_o.tag);
            check_result("resp_o.result", vec_exp[vec], resp_o.result);
            // first pass runs without stalls
            if (resp_count < num_vec) begin
                check_cycles("response latency", 2, cycle_cnt - accept_cycle[resp_count]);
                if (resp_count > 0) begin
                    check_cycles("response spacing", 1, cycle_cnt - last_resp_cycle);
                end
            end
            last_resp_cycle = cycle_cnt;
            resp_count++;
        end
    endtask

    // handshakes sampled mid-cycle, they transfer on the next rising edge
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (req_valid_i && req_ready_o) begin
                accept_cycle.push_back(cycle_cnt);
            end
            if (resp_valid_o && resp_ready_i) begin
                check_response();
            end
        end
    end

    // sink, stalls about one cycle in three outside the burst pass
    initial begin
        int unsigned draw;
        draw = $urandom(91);
        forever begin
            @(posedge clk_i);
            #2;
            if (burst_mode) begin
                resp_ready_i = 1'b1;
            end else begin
                resp_ready_i = (draw % 3) != 0;
                draw         = $urandom;
            end
        end
    end

    // bound of 12 cycles per vector, plus reset
    initial begin
        longint unsigned limit_ns;
        wait (vectors_loaded);
        limit_ns = 64'd20 * num_vec * 12 + 64'd20 * 10;
        #(limit_ns);
        $display("timeout, responses stopped before all requests were answered");
        abort_run();
    end

    initial begin
        int unsigned i;
        arst_n_i     = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;

        load_vectors();
        if (num_vec == 0) begin
            $display("the vector file holds no vectors");
            abort_run();
        end
        total_reqs     = 2 * num_vec;
        vectors_loaded = 1'b1;

        repeat (10) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        if (resp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            $display("after reset resp_valid_o is not low or req_ready_o is not high");
            abort_run();
        end
        @(posedge clk_i);
        #2;

        // back-to-back burst with the sink always ready
        for (i = 0; i < num_vec; i++) begin
            send_request(i);
        end
        req_valid_i = 1'b0;
        wait (resp_count == num_vec);
        @(negedge clk_i);
        burst_mode = 1'b0;
        @(posedge clk_i);
        #2;

        // same vectors again under random back-pressure
        for (i = num_vec; i < total_reqs; i++) begin
            send_request(i);
        end
        req_valid_i = 1'b0;
        wait (resp_count == total_reqs);
        repeat (4) @(negedge clk_i);

        if (resp_valid_o) begin
            $display("resp_valid_o is still high after the last response");
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* verif/alu_vectors.txt */
# columns: op code, rs1, rs2, expected result, all in hex
# op codes follow alu_op_t, the testbench assigns the tags
00 0000000000000005 0000000000000007 000000000000000c
00 7fffffffffffffff 0000000000000001 8000000000000000
01 0000000000000003 0000000000000005 fffffffffffffffe
01 8000000000000000 0000000000000001 7fffffffffffffff
02 000000007fffffff 0000000000000001 ffffffff80000000
03 0000000000000000 0000000000000001 ffffffffffffffff
04 ffffffffffffffff 0000000000000001 0000000000000001
05 ffffffffffffffff 0000000000000001 0000000000000000
04 8000000000000000 7fffffffffffffff 0000000000000001
05 0000000000000001 8000000000000000 0000000000000001
06 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff 000f000f000f000f
07 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff 0fff0fff0fff0fff
08 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff 0ff00ff00ff00ff0
09 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff 00f000f00f000f00
0a 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff f0fff0ffff0fff0f
0b 00ff00ff0f0f0f0f 0f0f0f0f00ff00ff f00ff00ff00ff00f
0c 0000000000000001 000000000000003f 8000000000000000
0c 00000000000000ff 0000000000000040 00000000000000ff
0d f000000000000000 0000000000000044 0f00000000000000
0e 8000000000000000 000000000000003f ffffffffffffffff
0f 0000000000000001 000000000000001f ffffffff80000000
0f 0000000012345678 0000000000000024 0000000023456780
10 ffffffff80000000 000000000000001f 0000000000000001
11 0000000080000000 0000000000000004 fffffffff8000000
12 ffffffff80000001 0000000000000001 0000000100000002
12 abcdef0112345678 0000000000000020 1234567800000000
13 8000000000000001 0000000000000001 0000000000000003
14 0123456789abcdef 0000000000000010 cdef0123456789ab
15 0000000012345678 0000000000000004 0000000023456781
16 ffffffff12345678 0000000000000008 0000000078123456
17 0000000000000000 000000000000003f 8000000000000000
17 00000000000000f0 0000000000000043 00000000000000f8
18 ffffffffffffffff 0000000000000020 fffffffeffffffff
19 0000000000000000 000000000000001f 0000000080000000
1a 8000000000000000 000000000000003f 0000000000000001
1a 0000000000000010 0000000000000044 0000000000000001
